// ==== all.f ====
cpu_pkg.sv
fwd_if.sv
regfile.sv
bypass_unit.sv
id_stage.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu.sv

// ==== bypass_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module bypass_unit (
    input  wire  [cpu_pkg::REG_IDX_W-1:0] index1,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] index2,
    input  wire  [cpu_pkg::XLEN-1:0]      reg1,
    input  wire  [cpu_pkg::XLEN-1:0]      reg2,
    fwd_if.sink                           ex_fwd,
    fwd_if.sink                           mem_fwd,
    fwd_if.sink                           wb_fwd,
    output logic [cpu_pkg::XLEN-1:0]      bypass_reg1,
    output logic [cpu_pkg::XLEN-1:0]      bypass_reg2,
    output logic                          load_use
);
    import cpu_pkg::*;

    logic ex_hit1, mem_hit1, wb_hit1;
    logic ex_hit2, mem_hit2, wb_hit2;

    // live producer writing this source, r0 never matches
    function automatic logic hit(input logic valid, input logic wen,
                                 input logic [REG_IDX_W-1:0] windex,
                                 input logic [REG_IDX_W-1:0] index);
        return valid && wen && (windex == index) && (index != '0);
    endfunction

    assign ex_hit1  = hit(ex_fwd.valid, ex_fwd.wen, ex_fwd.windex, index1);
    assign mem_hit1 = hit(mem_fwd.valid, mem_fwd.wen, mem_fwd.windex, index1);
    assign wb_hit1  = hit(wb_fwd.valid, wb_fwd.wen, wb_fwd.windex, index1);
    assign ex_hit2  = hit(ex_fwd.valid, ex_fwd.wen, ex_fwd.windex, index2);
    assign mem_hit2 = hit(mem_fwd.valid, mem_fwd.wen, mem_fwd.windex, index2);
    assign wb_hit2  = hit(wb_fwd.valid, wb_fwd.wen, wb_fwd.windex, index2);

    // youngest producer first
    always_comb begin
        if (ex_hit1)       bypass_reg1 = ex_fwd.wdata;
        else if (mem_hit1) bypass_reg1 = mem_fwd.wdata;
        else if (wb_hit1)  bypass_reg1 = wb_fwd.wdata;
        else               bypass_reg1 = reg1;
        if (ex_hit2)       bypass_reg2 = ex_fwd.wdata;
        else if (mem_hit2) bypass_reg2 = mem_fwd.wdata;
        else if (wb_hit2)  bypass_reg2 = wb_fwd.wdata;
        else               bypass_reg2 = reg2;
    end

    // load data shows up in MEM, so one bubble is needed
    assign load_use = ex_fwd.is_load && (ex_hit1 || ex_hit2);

endmodule

`default_nettype wire

// ==== cpu_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_assertions (
    input wire                           clk,
    input wire                           arst_n,
    input wire                           inst_valid,
    input wire                           inst_ready,
    input wire  [cpu_pkg::XLEN-1:0]      inst_pc,
    input wire                           load_use,
    input wire                           commit_valid,
    input wire  [cpu_pkg::XLEN-1:0]      commit_pc,
    input wire                           commit_wen,
    input wire  [cpu_pkg::REG_IDX_W-1:0] commit_windex
);

    // number of failed protocol checks so far
    int fail_count = 0;

    // nothing commits and ID takes input in the first cycle out of reset
    a_idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !commit_valid && inst_ready)
        else begin
            fail_count++;
            $error("pipeline not idle and ready in the first cycle after reset");
        end

    // a load-use bubble lasts one cycle only
    a_single_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !inst_ready |=> inst_ready)
        else begin
            fail_count++;
            $error("inst_ready low for two cycles in a row");
        end

    // r0 is never reported as written
    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        commit_wen |-> commit_windex != '0)
        else begin
            fail_count++;
            $error("commit_wen set with r0 as destination");
        end

    // without a bubble in ID the commit comes five cycles after acceptance
    a_five_cycle_commit: assert property (@(posedge clk) disable iff (!arst_n)
        (inst_valid && inst_ready) ##1 !load_use
        |-> ##4 (commit_valid && commit_pc == $past(inst_pc, 5)))
        else begin
            fail_count++;
            $error("unstalled instruction did not commit five cycles after acceptance");
        end

endmodule

bind cpu_top cpu_assertions u_assert (.*);

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // datapath and pc width
    localparam int XLEN      = 32;
    // register file geometry
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;
    // raw immediate as it arrives with the instruction
    localparam int IMM_W     = 12;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        ADDI = 3'd5,
        LD   = 3'd6,
        ST   = 3'd7
    } op_e;

    // decoded instruction with bypassed operands, ID to EX
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        op_e                  op;
        logic [REG_IDX_W-1:0] rd;
        logic                 wen;
        logic [XLEN-1:0]      src_a;
        logic [XLEN-1:0]      src_b;
        // already sign extended
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      st_data;
    } id_ex_t;

    // alu result or memory address, EX to MEM
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic                 is_load;
        logic                 is_store;
        logic [REG_IDX_W-1:0] rd;
        logic                 wen;
        logic [XLEN-1:0]      result;
        logic [XLEN-1:0]      st_data;
    } ex_mem_t;

    // final writeback record, MEM to WB
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic                 wen;
        logic [XLEN-1:0]      result;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
    parameter int unsigned DMEM_WORDS = 32
) (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           inst_valid,
    output logic                          inst_ready,
    input  wire  [cpu_pkg::XLEN-1:0]      inst_pc,
    input  wire  cpu_pkg::op_e            inst_op,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] inst_rd,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] inst_rj,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] inst_rk,
    input  wire  [cpu_pkg::IMM_W-1:0]     inst_imm,
    output logic                          commit_valid,
    output logic [cpu_pkg::XLEN-1:0]      commit_pc,
    output logic                          commit_wen,
    output logic [cpu_pkg::REG_IDX_W-1:0] commit_windex,
    output logic [cpu_pkg::XLEN-1:0]      commit_wdata
);
    import cpu_pkg::*;

    // stage to stage handshake
    logic id_right_valid, id_right_ready;
    logic ex_right_valid, ex_right_ready;
    logic mem_right_valid, mem_right_ready;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    // operand read and bypass
    logic [REG_IDX_W-1:0] reg_index1, reg_index2;
    logic [XLEN-1:0]      rf_rdata1, rf_rdata2;
    logic [XLEN-1:0]      bypass_reg1, bypass_reg2;
    logic                 load_use;
    // writeback port
    logic                 rf_we;
    logic [REG_IDX_W-1:0] rf_waddr;
    logic [XLEN-1:0]      rf_wdata;

    fwd_if ex_fwd ();
    fwd_if mem_fwd ();
    fwd_if wb_fwd ();

    id_stage u_id (
        .clk, .arst_n, .inst_valid, .inst_ready, .inst_pc, .inst_op,
        .inst_rd, .inst_rj, .inst_rk, .inst_imm, .reg_index1, .reg_index2,
        .reg_data1(bypass_reg1), .reg_data2(bypass_reg2), .load_use,
        .right_valid(id_right_valid), .right_ready(id_right_ready), .id_ex
    );

    regfile u_regfile (
        .clk, .arst_n, .raddr1(reg_index1), .raddr2(reg_index2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    bypass_unit u_bypass (
        .index1(reg_index1), .index2(reg_index2), .reg1(rf_rdata1), .reg2(rf_rdata2),
        .ex_fwd, .mem_fwd, .wb_fwd, .bypass_reg1, .bypass_reg2, .load_use
    );

    exe_stage u_exe (
        .clk, .arst_n, .left_valid(id_right_valid), .left_ready(id_right_ready), .id_ex,
        .right_valid(ex_right_valid), .right_ready(ex_right_ready), .ex_mem, .fwd(ex_fwd)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk, .arst_n, .left_valid(ex_right_valid), .left_ready(ex_right_ready), .ex_mem,
        .right_valid(mem_right_valid), .right_ready(mem_right_ready), .mem_wb, .fwd(mem_fwd)
    );

    wb_stage u_wb (
        .clk, .arst_n, .left_valid(mem_right_valid), .left_ready(mem_right_ready), .mem_wb,
        .rf_we, .rf_waddr, .rf_wdata, .fwd(wb_fwd), .commit_valid, .commit_pc,
        .commit_wen, .commit_windex, .commit_wdata
    );

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exe_stage (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              left_valid,
    output logic             left_ready,
    input  wire  cpu_pkg::id_ex_t  id_ex,
    output logic             right_valid,
    input  wire              right_ready,
    output cpu_pkg::ex_mem_t ex_mem,
    fwd_if.source            fwd
);
    import cpu_pkg::*;

    logic            ex_valid;
    id_ex_t          ex_r;
    logic [XLEN-1:0] alu_out;

    assign left_ready  = !ex_valid || right_ready;
    assign right_valid = ex_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (left_ready) begin
            ex_valid <= left_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (left_valid && left_ready) begin
            ex_r <= id_ex;
        end
    end

    // register ops use src_b, the rest is base plus offset
    always_comb begin
        case (ex_r.op)
            ADD:     alu_out = ex_r.src_a + ex_r.src_b;
            SUB:     alu_out = ex_r.src_a - ex_r.src_b;
            AND:     alu_out = ex_r.src_a & ex_r.src_b;
            OR:      alu_out = ex_r.src_a | ex_r.src_b;
            XOR:     alu_out = ex_r.src_a ^ ex_r.src_b;
            default: alu_out = ex_r.src_a + ex_r.imm;
        endcase
    end

    always_comb begin
        ex_mem.pc       = ex_r.pc;
        ex_mem.is_load  = (ex_r.op == LD);
        ex_mem.is_store = (ex_r.op == ST);
        ex_mem.rd       = ex_r.rd;
        ex_mem.wen      = ex_r.wen;
        ex_mem.result   = alu_out;
        ex_mem.st_data  = ex_r.st_data;
    end

    // for a load wdata is the address, bypass stalls on it
    assign fwd.valid   = ex_valid;
    assign fwd.wen     = ex_r.wen;
    assign fwd.windex  = ex_r.rd;
    assign fwd.wdata   = alu_out;
    assign fwd.is_load = (ex_r.op == LD);

endmodule

`default_nettype wire

// ==== fwd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface fwd_if;
    import cpu_pkg::*;

    // stage holds an item this cycle
    logic                 valid;
    // item will write the register file
    logic                 wen;
    logic [REG_IDX_W-1:0] windex;
    logic [XLEN-1:0]      wdata;
    // load still in EX, wdata is only the address
    logic                 is_load;

    // producing stage side
    modport source (output valid, wen, windex, wdata, is_load);
    // bypass unit side
    modport sink (input valid, wen, windex, wdata, is_load);

endinterface

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           inst_valid,
    output logic                          inst_ready,
    input  wire  [cpu_pkg::XLEN-1:0]      inst_pc,
    input  wire  cpu_pkg::op_e            inst_op,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] inst_rd,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] inst_rj,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] inst_rk,
    input  wire  [cpu_pkg::IMM_W-1:0]     inst_imm,
    output logic [cpu_pkg::REG_IDX_W-1:0] reg_index1,
    output logic [cpu_pkg::REG_IDX_W-1:0] reg_index2,
    input  wire  [cpu_pkg::XLEN-1:0]      reg_data1,
    input  wire  [cpu_pkg::XLEN-1:0]      reg_data2,
    input  wire                           load_use,
    output logic                          right_valid,
    input  wire                           right_ready,
    output cpu_pkg::id_ex_t               id_ex
);
    import cpu_pkg::*;

    logic                 id_valid;
    logic [XLEN-1:0]      pc_r;
    op_e                  op_r;
    logic [REG_IDX_W-1:0] rd_r;
    logic [REG_IDX_W-1:0] rj_r;
    logic [REG_IDX_W-1:0] rk_r;
    logic [IMM_W-1:0]     imm_r;
    logic [XLEN-1:0]      imm_ext;
    logic                 use_imm;

    // hold back while a load in EX feeds a source
    assign right_valid = id_valid && !load_use;
    // empty, or the held instruction moves on this cycle
    assign inst_ready  = !id_valid || (right_valid && right_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else if (inst_ready) begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            pc_r  <= inst_pc;
            op_r  <= inst_op;
            rd_r  <= inst_rd;
            rj_r  <= inst_rj;
            rk_r  <= inst_rk;
            imm_r <= inst_imm;
        end
    end

    assign reg_index1 = rj_r;
    assign reg_index2 = rk_r;
    assign imm_ext    = {{(XLEN-IMM_W){imm_r[IMM_W-1]}}, imm_r};
    // immediate forms take imm as second operand
    assign use_imm    = (op_r == ADDI) || (op_r == LD) || (op_r == ST);

    always_comb begin
        id_ex.pc      = pc_r;
        id_ex.op      = op_r;
        id_ex.rd      = rd_r;
        // no write for r0 or stores
        id_ex.wen     = (rd_r != '0) && (op_r != ST);
        id_ex.src_a   = reg_data1;
        id_ex.src_b   = use_imm ? imm_ext : reg_data2;
        id_ex.imm     = imm_ext;
        // store data comes from rk
        id_ex.st_data = reg_data2;
    end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
    parameter int unsigned DMEM_WORDS = 32
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    left_valid,
    output logic                   left_ready,
    input  wire  cpu_pkg::ex_mem_t ex_mem,
    output logic                   right_valid,
    input  wire                    right_ready,
    output cpu_pkg::mem_wb_t       mem_wb,
    fwd_if.source                  fwd
);
    import cpu_pkg::*;

    localparam int ADDR_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic              mem_valid;
    ex_mem_t           mem_r;
    logic [XLEN-1:0]   dmem [DMEM_WORDS];
    logic [ADDR_W-1:0] dmem_idx;
    logic [XLEN-1:0]   mem_result;

    assign left_ready  = !mem_valid || right_ready;
    assign right_valid = mem_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_valid <= 1'b0;
        end else if (left_ready) begin
            mem_valid <= left_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (left_valid && left_ready) begin
            mem_r <= ex_mem;
        end
    end

    // word address, wrapped into the ram
    assign dmem_idx = ADDR_W'((mem_r.result >> 2) % DMEM_WORDS);

    // store commits to ram as it leaves for WB
    always_ff @(posedge clk) begin
        if (mem_valid && mem_r.is_store && right_ready) begin
            dmem[dmem_idx] <= mem_r.st_data;
        end
    end

    // loads swap the address for the read word
    assign mem_result = mem_r.is_load ? dmem[dmem_idx] : mem_r.result;

    always_comb begin
        mem_wb.pc     = mem_r.pc;
        mem_wb.rd     = mem_r.rd;
        mem_wb.wen    = mem_r.wen;
        mem_wb.result = mem_result;
    end

    assign fwd.valid   = mem_valid;
    assign fwd.wen     = mem_r.wen;
    assign fwd.windex  = mem_r.rd;
    assign fwd.wdata   = mem_result;
    assign fwd.is_load = 1'b0;

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] raddr1,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] raddr2,
    output logic [cpu_pkg::XLEN-1:0]      rdata1,
    output logic [cpu_pkg::XLEN-1:0]      rdata2,
    input  wire                           we,
    input  wire  [cpu_pkg::REG_IDX_W-1:0] waddr,
    input  wire  [cpu_pkg::XLEN-1:0]      wdata
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // writes land on the edge, r0 is skipped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int DMEM_WORDS   = 32;
    localparam int NUM_RANDOM   = 300;
    // directed prologue plus random body
    localparam int NUM_INSTR    = 6 + NUM_RANDOM;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic                 wen;
        logic [REG_IDX_W-1:0] windex;
        logic [XLEN-1:0]      wdata;
    } commit_t;

    logic                 clk;
    logic                 arst_n;
    logic                 inst_valid;
    logic                 inst_ready;
    logic [XLEN-1:0]      inst_pc;
    op_e                  inst_op;
    logic [REG_IDX_W-1:0] inst_rd;
    logic [REG_IDX_W-1:0] inst_rj;
    logic [REG_IDX_W-1:0] inst_rk;
    logic [IMM_W-1:0]     inst_imm;
    logic                 commit_valid;
    logic [XLEN-1:0]      commit_pc;
    logic                 commit_wen;
    logic [REG_IDX_W-1:0] commit_windex;
    logic [XLEN-1:0]      commit_wdata;

    // reference machine state
    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [XLEN-1:0] model_mem [DMEM_WORDS];
    // words that some store has already reached
    logic            written [DMEM_WORDS];
    commit_t         exp_q [$];
    logic [31:0]     lfsr;
    logic [XLEN-1:0] next_pc;

    cpu_top #(.DMEM_WORDS(DMEM_WORDS)) DUT (
        .clk, .arst_n, .inst_valid, .inst_ready, .inst_pc, .inst_op,
        .inst_rd, .inst_rj, .inst_rk, .inst_imm, .commit_valid, .commit_pc,
        .commit_wen, .commit_windex, .commit_wdata
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps from x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [XLEN-1:0] sext(input logic [IMM_W-1:0] imm);
        return {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

    // ram word hit by base register plus offset
    function automatic int word_of(input logic [REG_IDX_W-1:0] rj, input logic [IMM_W-1:0] imm);
        logic [XLEN-1:0] addr;
        addr = model_regs[rj] + sext(imm);
        return int'((addr >> 2) % DMEM_WORDS);
    endfunction

    // executes one accepted instruction and queues its commit
    task automatic model_step(input op_e op, input logic [REG_IDX_W-1:0] rd, rj, rk,
                              input logic [IMM_W-1:0] imm);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        commit_t         rec;
        int              idx;
        a   = model_regs[rj];
        b   = model_regs[rk];
        idx = word_of(rj, imm);
        res = '0;
        case (op)
            ADD:  res = a + b;
            SUB:  res = a - b;
            AND:  res = a & b;
            OR:   res = a | b;
            XOR:  res = a ^ b;
            ADDI: res = a + sext(imm);
            LD:   res = model_mem[idx];
            default: begin
                // store data from rk
                model_mem[idx] = b;
                written[idx]   = 1'b1;
            end
        endcase
        rec.pc     = inst_pc;
        rec.wen    = (rd != '0) && (op != ST);
        rec.windex = rd;
        rec.wdata  = res;
        if (rec.wen) begin
            model_regs[rd] = res;
        end
        exp_q.push_back(rec);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            inst_valid = 1'b0;
        end
    endtask

    // fields stay put until ID takes them
    task automatic send(input op_e op, input logic [REG_IDX_W-1:0] rd, rj, rk,
                        input logic [IMM_W-1:0] imm);
        @(negedge clk);
        inst_valid = 1'b1;
        inst_pc    = next_pc;
        inst_op    = op;
        inst_rd    = rd;
        inst_rj    = rj;
        inst_rk    = rk;
        inst_imm   = imm;
        while (!inst_ready) begin
            @(negedge clk);
        end
        // taken on the coming rising edge
        model_step(op, rd, rj, rk, imm);
        next_pc = next_pc + 4;
    endtask

    task automatic send_random();
        op_e                  op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rj;
        logic [REG_IDX_W-1:0] rk;
        logic [IMM_W-1:0]     imm;
        if (rand_bits(2) == 0) begin
            idle(1 + int'(rand_bits(1)));
        end
        op = op_e'(rand_bits(3));
        // only r0..r3 so most instructions depend on a recent one
        rd = REG_IDX_W'(rand_bits(2));
        rj = REG_IDX_W'(rand_bits(2));
        rk = REG_IDX_W'(rand_bits(2));
        if (op == LD || op == ST) begin
            imm = IMM_W'(rand_bits(3) << 2);
        end else begin
            imm = IMM_W'(rand_bits(IMM_W));
        end
        // loads only from words that hold stored data
        if (op == LD && !written[word_of(rj, imm)]) begin
            op = ST;
        end
        send(op, rd, rj, rk, imm);
    endtask

    task automatic report_wrong_value(input string what, input logic [XLEN-1:0] got,
                                      input logic [XLEN-1:0] expected);
        $display("MISMATCH at %0t ns: commit %s is %h, expected %h", $time, what, got, expected);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // registered commit outputs are settled at the falling edge
    always @(negedge clk) begin : check_commit
        commit_t head;
        if (arst_n && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("commit of pc %h arrived with no instruction outstanding", commit_pc);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                head = exp_q.pop_front();
                assert (commit_pc == head.pc)
                    else report_wrong_value("pc", commit_pc, head.pc);
                assert (commit_wen == head.wen)
                    else report_wrong_value("wen", commit_wen, head.wen);
                // index and data only mean something for a write
                if (head.wen) begin
                    assert (commit_windex == head.windex)
                        else report_wrong_value("windex", commit_windex, head.windex);
                    assert (commit_wdata == head.wdata)
                        else report_wrong_value("wdata", commit_wdata, head.wdata);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.u_assert.fail_count != 0) begin
            $display("a protocol assertion bound to the DUT failed");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_INSTR * 8 + RESET_CYCLES));
        $display("watchdog expired before all instructions committed");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_op    = ADD;
        inst_rd    = '0;
        inst_rj    = '0;
        inst_rk    = '0;
        inst_imm   = '0;
        lfsr       = 32'h6a7b_4780;
        next_pc    = 32'h1c00_0000;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        // store then reload of one word and a load-use pair
        // then r0 as target and as source
        send(ADDI, 5'd1, 5'd0, 5'd0, 12'h123);
        send(ST,   5'd0, 5'd0, 5'd1, 12'h008);
        send(LD,   5'd2, 5'd0, 5'd0, 12'h008);
        send(ADD,  5'd3, 5'd2, 5'd1, 12'h000);
        send(ADDI, 5'd0, 5'd1, 5'd0, 12'h7ff);
        send(OR,   5'd3, 5'd0, 5'd1, 12'h000);
        repeat (NUM_RANDOM) send_random();
        @(negedge clk);
        inst_valid = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // a stray commit in this quiet tail trips the checker
        repeat (8) @(negedge clk);
        if (DUT.u_assert.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("a protocol assertion bound to the DUT failed");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== wb_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_stage (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           left_valid,
    output logic                          left_ready,
    input  wire  cpu_pkg::mem_wb_t        mem_wb,
    output logic                          rf_we,
    output logic [cpu_pkg::REG_IDX_W-1:0] rf_waddr,
    output logic [cpu_pkg::XLEN-1:0]      rf_wdata,
    fwd_if.source                         fwd,
    output logic                          commit_valid,
    output logic [cpu_pkg::XLEN-1:0]      commit_pc,
    output logic                          commit_wen,
    output logic [cpu_pkg::REG_IDX_W-1:0] commit_windex,
    output logic [cpu_pkg::XLEN-1:0]      commit_wdata
);
    import cpu_pkg::*;

    logic    wb_valid;
    mem_wb_t wb_r;

    // WB never stalls
    assign left_ready = 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= left_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (left_valid) begin
            wb_r <= mem_wb;
        end
    end

    assign rf_we    = wb_valid && wb_r.wen;
    assign rf_waddr = wb_r.rd;
    assign rf_wdata = wb_r.result;

    assign fwd.valid   = wb_valid;
    assign fwd.wen     = wb_r.wen;
    assign fwd.windex  = wb_r.rd;
    assign fwd.wdata   = wb_r.result;
    assign fwd.is_load = 1'b0;

    // commit trace trails writeback by one cycle, zeroed when idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid  <= 1'b0;
            commit_pc     <= '0;
            commit_wen    <= 1'b0;
            commit_windex <= '0;
            commit_wdata  <= '0;
        end else begin
            commit_valid  <= wb_valid;
            commit_pc     <= wb_valid ? wb_r.pc : '0;
            commit_wen    <= wb_valid && wb_r.wen;
            commit_windex <= wb_valid ? wb_r.rd : '0;
            commit_wdata  <= wb_valid ? wb_r.result : '0;
        end
    end

endmodule

`default_nettype wire
